//--- verilog/sensor_video_pkg.sv
package sensor_video_pkg;

   typedef logic [11:0] pixel_t;   // one sensor data word
   typedef logic [11:0] row_t;     // row index inside vact
   typedef logic [11:0] col_t;     // column index inside bpf / hact
   typedef logic [15:0] count_t;   // cycle counts and line length

   // frame sequencing, order follows the line structure
   typedef enum logic [3:0] {
      s_stop,          // idle, waiting for trig
      s_pre_vact,      // trigger delay, whole lines
      s_first_line,    // blank line after vact rise
      s_bpf,           // black pixel flag
      s_pre_hact,      // gap before active pixels
      s_hact,          // active pixels
      s_after_hact,    // rest of the line
      s_last_line,     // blank line before vact fall
      s_frame_done     // single cycle, vact low
   } frame_state_t;

   localparam pixel_t LFSR_SEED = 12'hACE;   // must not be zero

endpackage

//--- verilog/sensor_regs_pkg.sv
package sensor_regs_pkg;

   localparam int ADDR_W = 8;
   localparam int DATA_W = 32;

   typedef logic [ADDR_W-1:0] apb_addr_t;
   typedef logic [DATA_W-1:0] apb_data_t;

   // register map, byte offsets
   localparam apb_addr_t REG_CTRL     = 8'h00;   // pattern, continuous
   localparam apb_addr_t REG_LINE_LEN = 8'h04;   // cycles per line
   localparam apb_addr_t REG_NCOLS    = 8'h08;   // hact length
   localparam apb_addr_t REG_NROWS    = 8'h0C;   // hact pulses per frame
   localparam apb_addr_t REG_NBPF     = 8'h10;   // bpf length, 0 = none
   localparam apb_addr_t REG_NGAP     = 8'h14;   // bpf to hact
   localparam apb_addr_t REG_TRIG_DLY = 8'h18;   // in lines
   localparam apb_addr_t REG_STATUS   = 8'h1C;   // read only

   // CTRL fields
   localparam int CTRL_PATTERN_BIT = 0;   // 0 ramp, 1 lfsr
   localparam int CTRL_CONT_BIT    = 1;   // free running frames

endpackage

//--- verilog/sensor_apb_regs.sv
`timescale 1ns/1ps

module sensor_apb_regs #(
   parameter sensor_video_pkg::count_t RESET_LINE_LEN = 16'd192
) (
   input  logic                       MCLK,
   input  logic                       c,
   input  sensor_regs_pkg::apb_addr_t paddr,
   input  logic                       psel,
   input  logic                       penable,
   input  logic                       pwrite,
   input  sensor_regs_pkg::apb_data_t pwdata,
   output sensor_regs_pkg::apb_data_t prdata,
   output logic                       pready,
   output logic                       pslverr,
   input  logic                       busy,               // live from fsm
   input  logic                       frame_done_pulse,
   output sensor_video_pkg::count_t   line_len,
   output sensor_video_pkg::col_t     ncols,
   output sensor_video_pkg::row_t     nrows,
   output sensor_video_pkg::count_t   nbpf,
   output sensor_video_pkg::count_t   ngap,
   output sensor_video_pkg::count_t   trig_dly,
   output logic                       pattern,
   output logic                       cont
);

   logic [7:0]                 sel;      // one hot, bit n = offset 4*n
   logic                       access;   // apb access phase
   logic                       bad;      // unmapped or read only write
   logic                       wr_en;
   sensor_regs_pkg::apb_data_t rdata;
   sensor_video_pkg::count_t   frame_cnt;

   assign access  = psel & penable;
   assign bad     = ~|sel | (pwrite & sel[7]);   // sel[7] is STATUS
   assign wr_en   = access & pwrite & ~bad;
   assign pready  = 1'b1;                        // zero wait states
   assign pslverr = access & bad;
   assign prdata  = (access & ~pwrite) ? rdata : '0;

   // single offset decode, feeds both the read mux and the write enables
   always_comb begin
      sel   = '0;
      rdata = '0;
      case (paddr)
         sensor_regs_pkg::REG_CTRL: begin
            sel[0] = 1'b1;
            rdata[sensor_regs_pkg::CTRL_PATTERN_BIT] = pattern;
            rdata[sensor_regs_pkg::CTRL_CONT_BIT]    = cont;
         end
         sensor_regs_pkg::REG_LINE_LEN: begin
            sel[1] = 1'b1;
            rdata  = sensor_regs_pkg::apb_data_t'(line_len);
         end
         sensor_regs_pkg::REG_NCOLS: begin
            sel[2] = 1'b1;
            rdata  = sensor_regs_pkg::apb_data_t'(ncols);
         end
         sensor_regs_pkg::REG_NROWS: begin
            sel[3] = 1'b1;
            rdata  = sensor_regs_pkg::apb_data_t'(nrows);
         end
         sensor_regs_pkg::REG_NBPF: begin
            sel[4] = 1'b1;
            rdata  = sensor_regs_pkg::apb_data_t'(nbpf);
         end
         sensor_regs_pkg::REG_NGAP: begin
            sel[5] = 1'b1;
            rdata  = sensor_regs_pkg::apb_data_t'(ngap);
         end
         sensor_regs_pkg::REG_TRIG_DLY: begin
            sel[6] = 1'b1;
            rdata  = sensor_regs_pkg::apb_data_t'(trig_dly);
         end
         sensor_regs_pkg::REG_STATUS: begin
            sel[7] = 1'b1;
            rdata  = {frame_cnt, 15'd0, busy};   // count in 31:16, busy in 0
         end
         default: ;                              // unmapped, sel stays zero
      endcase
   end

   always_ff @(posedge MCLK or posedge c) begin
      if (c) begin
         line_len  <= RESET_LINE_LEN;
         ncols     <= '0;
         nrows     <= '0;
         nbpf      <= '0;
         ngap      <= '0;
         trig_dly  <= '0;
         pattern   <= 1'b0;
         cont      <= 1'b0;
         frame_cnt <= '0;
      end else begin
         if (frame_done_pulse)
            frame_cnt <= frame_cnt + 1'b1;   // wraps at 16 bits
         if (wr_en) begin
            if (sel[0]) begin
               pattern <= pwdata[sensor_regs_pkg::CTRL_PATTERN_BIT];
               cont    <= pwdata[sensor_regs_pkg::CTRL_CONT_BIT];
            end
            if (sel[1])
               line_len <= sensor_video_pkg::count_t'(pwdata);
            if (sel[2])
               ncols <= sensor_video_pkg::col_t'(pwdata);
            if (sel[3])
               nrows <= sensor_video_pkg::row_t'(pwdata);
            if (sel[4])
               nbpf <= sensor_video_pkg::count_t'(pwdata);
            if (sel[5])
               ngap <= sensor_video_pkg::count_t'(pwdata);
            if (sel[6])
               trig_dly <= sensor_video_pkg::count_t'(pwdata);
         end
      end
   end

endmodule

//--- verilog/sensor_frame_fsm.sv
`timescale 1ns/1ps

module sensor_frame_fsm (
   input  logic                     MCLK,
   input  logic                     c,
   input  logic                     trig,       // one cycle start request
   input  sensor_video_pkg::count_t line_len,
   input  sensor_video_pkg::col_t   ncols,
   input  sensor_video_pkg::row_t   nrows,
   input  sensor_video_pkg::count_t nbpf,
   input  sensor_video_pkg::count_t ngap,
   input  sensor_video_pkg::count_t trig_dly,
   input  logic                     cont,
   output sensor_video_pkg::row_t   row,
   output sensor_video_pkg::col_t   col,
   output logic                     bpf_i,
   output logic                     hact_i,
   output logic                     vact_i,
   output logic                     busy,
   output logic                     frame_done_pulse
);

   sensor_video_pkg::frame_state_t state, state_n;
   sensor_video_pkg::count_t       cnt, cnt_n;       // cycles left in state
   sensor_video_pkg::count_t       lines, lines_n;   // delay lines left
   sensor_video_pkg::count_t       after;            // tail of the line
   sensor_video_pkg::row_t         row_n;
   sensor_video_pkg::col_t         col_n;
   logic                           bpf_n, hact_n, vact_n;
   // segment starts, resolved in order after the state case
   logic                           start_frame, end_row, start_row;
   logic                           start_gap, start_hact;

   assign after = line_len - nbpf - ngap - sensor_video_pkg::count_t'(ncols);
   assign busy             = (state != sensor_video_pkg::s_stop);
   assign frame_done_pulse = (state == sensor_video_pkg::s_frame_done);

   always_comb begin
      state_n     = state;
      cnt_n       = cnt;
      lines_n     = lines;
      row_n       = row;
      col_n       = col;
      bpf_n       = bpf_i;
      hact_n      = hact_i;
      vact_n      = vact_i;
      start_frame = 1'b0;
      end_row     = 1'b0;
      start_row   = 1'b0;
      start_gap   = 1'b0;
      start_hact  = 1'b0;
      if (cnt != '0) begin
         cnt_n = cnt - 1'b1;
         if (bpf_i | hact_i)
            col_n = col + 1'b1;   // column runs over bpf and hact
      end else begin
         case (state)
            sensor_video_pkg::s_stop, sensor_video_pkg::s_frame_done: begin
               state_n = sensor_video_pkg::s_stop;
               if (frame_done_pulse && cont)
                  start_frame = 1'b1;               // back to back, no delay
               else if (trig && trig_dly == '0)
                  start_frame = 1'b1;
               else if (trig) begin
                  state_n = sensor_video_pkg::s_pre_vact;
                  cnt_n   = line_len - 1'b1;
                  lines_n = trig_dly - 1'b1;
               end
            end
            sensor_video_pkg::s_pre_vact: begin
               if (lines == '0)
                  start_frame = 1'b1;
               else begin
                  lines_n = lines - 1'b1;
                  cnt_n   = line_len - 1'b1;
               end
            end
            sensor_video_pkg::s_first_line: begin
               row_n     = '0;
               start_row = 1'b1;
            end
            sensor_video_pkg::s_bpf: begin
               bpf_n     = 1'b0;
               start_gap = 1'b1;
            end
            sensor_video_pkg::s_pre_hact:
               start_hact = 1'b1;
            sensor_video_pkg::s_hact: begin
               hact_n = 1'b0;
               row_n  = row + 1'b1;
               if (after != '0) begin
                  state_n = sensor_video_pkg::s_after_hact;
                  cnt_n   = after - 1'b1;
               end else
                  end_row = 1'b1;                   // line fully used by bpf+gap+hact
            end
            sensor_video_pkg::s_after_hact:
               end_row = 1'b1;
            sensor_video_pkg::s_last_line: begin
               vact_n  = 1'b0;
               state_n = sensor_video_pkg::s_frame_done;
            end
            default:
               state_n = sensor_video_pkg::s_stop;
         endcase
      end
      if (start_frame) begin
         state_n = sensor_video_pkg::s_first_line;
         vact_n  = 1'b1;
         cnt_n   = line_len - 1'b1;
      end
      if (end_row) begin
         if (row_n == nrows) begin
            state_n = sensor_video_pkg::s_last_line;
            cnt_n   = line_len - 1'b1;
         end else
            start_row = 1'b1;
      end
      if (start_row) begin
         col_n = '0;
         if (nbpf != '0) begin
            state_n = sensor_video_pkg::s_bpf;
            bpf_n   = 1'b1;
            cnt_n   = nbpf - 1'b1;
         end else
            start_gap = 1'b1;
      end
      if (start_gap) begin
         if (ngap != '0) begin
            state_n = sensor_video_pkg::s_pre_hact;
            cnt_n   = ngap - 1'b1;
         end else
            start_hact = 1'b1;
      end
      if (start_hact) begin
         state_n = sensor_video_pkg::s_hact;
         hact_n  = 1'b1;
         col_n   = '0;                              // restart at hact
         cnt_n   = sensor_video_pkg::count_t'(ncols) - 1'b1;
      end
   end

   always_ff @(posedge MCLK or posedge c) begin
      if (c) begin
         state  <= sensor_video_pkg::s_stop;
         cnt    <= '0;
         lines  <= '0;
         row    <= '0;
         col    <= '0;
         bpf_i  <= 1'b0;
         hact_i <= 1'b0;
         vact_i <= 1'b0;
      end else begin
         state  <= state_n;
         cnt    <= cnt_n;
         lines  <= lines_n;
         row    <= row_n;
         col    <= col_n;
         bpf_i  <= bpf_n;
         hact_i <= hact_n;
         vact_i <= vact_n;
      end
   end

endmodule

//--- verilog/sensor_pixel_out.sv
`timescale 1ns/1ps

module sensor_pixel_out (
   input  logic                     MCLK,
   input  logic                     c,
   input  sensor_video_pkg::row_t   row,
   input  sensor_video_pkg::col_t   col,
   input  logic                     bpf_i,
   input  logic                     hact_i,
   input  logic                     vact_i,
   input  logic                     pattern,     // 0 ramp, 1 lfsr
   output sensor_video_pkg::pixel_t d,
   output logic                     bpf,
   output logic                     hact,
   output logic                     vact,
   output logic                     vact_start
);

   sensor_video_pkg::pixel_t lfsr;
   sensor_video_pkg::pixel_t lfsr_next;
   sensor_video_pkg::pixel_t ramp;
   logic                     active;      // bpf or hact this cycle
   logic                     vact_rise;

   assign active    = bpf_i | hact_i;
   assign vact_rise = vact_i & ~vact;             // vact is last cycle's vact_i
   assign ramp      = {row[11:8], 8'h00} + col;   // wraps mod 4096

   // fibonacci, taps 12 6 4 1
   assign lfsr_next = {lfsr[10:0], lfsr[11] ^ lfsr[5] ^ lfsr[3] ^ lfsr[0]};

   always_ff @(posedge MCLK or posedge c) begin
      if (c) begin
         d          <= '0;
         bpf        <= 1'b0;
         hact       <= 1'b0;
         vact       <= 1'b0;
         vact_start <= 1'b0;
         lfsr       <= sensor_video_pkg::LFSR_SEED;
      end else begin
         bpf        <= bpf_i;
         hact       <= hact_i;
         vact       <= vact_i;
         vact_start <= vact_rise;
         if (vact_rise)
            lfsr <= sensor_video_pkg::LFSR_SEED;   // same pattern every frame
         else if (active)
            lfsr <= lfsr_next;
         if (!active)
            d <= '0;                                // blank outside bpf/hact
         else if (pattern)
            d <= lfsr;
         else
            d <= ramp;
      end
   end

endmodule

//--- verilog/sensor_top.sv
`timescale 1ns/1ps

module sensor_top #(
   parameter sensor_video_pkg::count_t RESET_LINE_LEN = 16'd192
) (
   input  logic                       MCLK,
   input  logic                       c,
   input  sensor_regs_pkg::apb_addr_t paddr,
   input  logic                       psel,
   input  logic                       penable,
   input  logic                       pwrite,
   input  sensor_regs_pkg::apb_data_t pwdata,
   output sensor_regs_pkg::apb_data_t prdata,
   output logic                       pready,
   output logic                       pslverr,
   input  logic                       trig,
   output sensor_video_pkg::pixel_t   d,
   output logic                       bpf,
   output logic                       hact,
   output logic                       vact,
   output logic                       vact_start
);

   // frame configuration
   sensor_video_pkg::count_t line_len;
   sensor_video_pkg::col_t   ncols;
   sensor_video_pkg::row_t   nrows;
   sensor_video_pkg::count_t nbpf;
   sensor_video_pkg::count_t ngap;
   sensor_video_pkg::count_t trig_dly;
   logic                     pattern;
   logic                     cont;
   // fsm status back to regs
   logic                     busy;
   logic                     frame_done_pulse;
   // fsm to pixel stage, one cycle ahead of the pins
   sensor_video_pkg::row_t   row;
   sensor_video_pkg::col_t   col;
   logic                     bpf_i;
   logic                     hact_i;
   logic                     vact_i;

   sensor_apb_regs #(
      .RESET_LINE_LEN (RESET_LINE_LEN)
   ) u_regs (
      .MCLK             (MCLK),
      .c                (c),
      .paddr            (paddr),
      .psel             (psel),
      .penable          (penable),
      .pwrite           (pwrite),
      .pwdata           (pwdata),
      .prdata           (prdata),
      .pready           (pready),
      .pslverr          (pslverr),
      .busy             (busy),
      .frame_done_pulse (frame_done_pulse),
      .line_len         (line_len),
      .ncols            (ncols),
      .nrows            (nrows),
      .nbpf             (nbpf),
      .ngap             (ngap),
      .trig_dly         (trig_dly),
      .pattern          (pattern),
      .cont             (cont)
   );

   sensor_frame_fsm u_fsm (
      .MCLK             (MCLK),
      .c                (c),
      .trig             (trig),
      .line_len         (line_len),
      .ncols            (ncols),
      .nrows            (nrows),
      .nbpf             (nbpf),
      .ngap             (ngap),
      .trig_dly         (trig_dly),
      .cont             (cont),
      .row              (row),
      .col              (col),
      .bpf_i            (bpf_i),
      .hact_i           (hact_i),
      .vact_i           (vact_i),
      .busy             (busy),
      .frame_done_pulse (frame_done_pulse)
   );

   sensor_pixel_out u_pix (
      .MCLK       (MCLK),
      .c          (c),
      .row        (row),
      .col        (col),
      .bpf_i      (bpf_i),
      .hact_i     (hact_i),
      .vact_i     (vact_i),
      .pattern    (pattern),
      .d          (d),
      .bpf        (bpf),
      .hact       (hact),
      .vact       (vact),
      .vact_start (vact_start)
   );

endmodule

//--- verif/sensor_tb.sv
`timescale 1ns/1ps

module sensor_tb;

   logic                       MCLK;
   logic                       c;
   sensor_regs_pkg::apb_addr_t paddr;
   logic                       psel, penable, pwrite;
   sensor_regs_pkg::apb_data_t pwdata, prdata;
   logic                       pready, pslverr;
   logic                       trig;
   sensor_video_pkg::pixel_t   d;
   logic                       bpf, hact, vact, vact_start;

   logic [31:0] vmem [0:287];   // 9 words per vector
   int          cycle = 0;
   int          limit = 0;      // timeout, 0 until vectors are read
   // reference model state, updated by the monitor
   sensor_video_pkg::count_t ll_m, ncols_m, nrows_m, nbpf_m;
   logic                     pattern_m;
   sensor_video_pkg::pixel_t lfsr_m;
   sensor_video_pkg::row_t   row_m;
   sensor_video_pkg::col_t   col_m;
   logic                     prev_vact = 0, prev_hact = 0, prev_bpf = 0;
   int hact_len, bpf_len, hact_cnt, last_rise, start_cyc, fall_cyc = 0, last_gap;
   int frames_started = 0, frames_done = 0;
   logic [31:0] frame_sum, last_sum;

   sensor_top #(.RESET_LINE_LEN(16'd192)) dut0 (
      .MCLK(MCLK), .c(c), .paddr(paddr), .psel(psel), .penable(penable),
      .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
      .pslverr(pslverr), .trig(trig), .d(d), .bpf(bpf), .hact(hact),
      .vact(vact), .vact_start(vact_start)
   );

   always #20 MCLK = ~MCLK;   // 40 ns period

   always @(posedge MCLK) begin
      cycle <= cycle + 1;
      if (limit != 0 && cycle >= limit) begin
         $display("run timed out after %0d cycles", cycle);
         $display("tests failed");
         $fatal(1);
      end
   end

   task automatic check_pixel(string name, sensor_video_pkg::pixel_t exp,
                              sensor_video_pkg::pixel_t act);
      if (exp !== act) begin
         $display("FAIL %s expected %03h actual %03h at cycle %0d", name, exp, act, cycle);
         $display("tests failed");
         $fatal(1);
      end
   endtask

   task automatic check_count(string name, sensor_video_pkg::count_t exp,
                              sensor_video_pkg::count_t act);
      if (exp !== act) begin
         $display("FAIL %s expected %0d actual %0d at cycle %0d", name, exp, act, cycle);
         $display("tests failed");
         $fatal(1);
      end
   endtask

   task automatic check_apb(string name, sensor_regs_pkg::apb_data_t exp,
                            sensor_regs_pkg::apb_data_t act);
      if (exp !== act) begin
         $display("FAIL %s expected %08h actual %08h", name, exp, act);
         $display("tests failed");
         $fatal(1);
      end
   endtask

   // reference pattern generators
   function automatic sensor_video_pkg::pixel_t lfsr_step(sensor_video_pkg::pixel_t v);
      logic fb;
      fb = v[11] ^ v[5] ^ v[3] ^ v[0];   // taps 12 6 4 1
      return (v << 1) | sensor_video_pkg::pixel_t'(fb);
   endfunction

   function automatic sensor_video_pkg::pixel_t ramp_px(sensor_video_pkg::row_t r,
                                                        sensor_video_pkg::col_t col_v);
      int unsigned val;
      val = (int'(r) / 256) * 256 + int'(col_v);   // upper row nibble above the column
      return sensor_video_pkg::pixel_t'(val % 4096);
   endfunction

   // setup then access phase, sampled mid access
   task automatic apb_xfer(input logic wr, input sensor_regs_pkg::apb_addr_t addr,
                           input sensor_regs_pkg::apb_data_t wdata,
                           output sensor_regs_pkg::apb_data_t rdata, output logic err);
      @(posedge MCLK);
      paddr   <= addr;
      pwrite  <= wr;
      pwdata  <= wdata;
      psel    <= 1'b1;
      penable <= 1'b0;
      @(posedge MCLK);
      penable <= 1'b1;
      @(negedge MCLK);
      rdata = prdata;
      err   = pslverr;
      check_apb("pready", 32'd1, 32'(pready));   // zero wait access
      @(posedge MCLK);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic write_reg(string name, sensor_regs_pkg::apb_addr_t addr,
                            sensor_regs_pkg::apb_data_t data, logic exp_err);
      sensor_regs_pkg::apb_data_t rd;
      logic                       err;
      apb_xfer(1'b1, addr, data, rd, err);
      check_apb({name, " write error"}, 32'(exp_err), 32'(err));
   endtask

   task automatic read_reg(string name, sensor_regs_pkg::apb_addr_t addr,
                           sensor_regs_pkg::apb_data_t exp, logic exp_err);
      sensor_regs_pkg::apb_data_t rd;
      logic                       err;
      apb_xfer(1'b0, addr, '0, rd, err);
      check_apb({name, " read error"}, 32'(exp_err), 32'(err));
      check_apb(name, exp, rd);
   endtask

   // output monitor and reference model, outputs are stable at negedge
   always @(negedge MCLK) begin
      sensor_video_pkg::pixel_t exp;
      if (!c) begin
         check_count("vact_start", 16'(vact && !prev_vact), 16'(vact_start));
         if (vact_start) begin
            lfsr_m    = sensor_video_pkg::LFSR_SEED;
            row_m     = '0;
            hact_cnt  = 0;
            frame_sum = '0;
            start_cyc = cycle;
            if (fall_cyc > 0)
               last_gap = cycle - fall_cyc;
            frames_started++;
         end
         if (prev_hact && !hact) begin
            check_count("hact length", ncols_m, 16'(hact_len));
            row_m++;                              // next row after each hact
         end
         if (prev_bpf && !bpf)
            check_count("bpf length", nbpf_m, 16'(bpf_len));
         if (hact && !prev_hact) begin
            if (hact_cnt > 0)
               check_count("line spacing", ll_m, 16'(cycle - last_rise));
            last_rise = cycle;
            hact_cnt++;
            hact_len  = 0;
            col_m     = '0;
         end
         if (bpf && !prev_bpf) begin
            bpf_len = 0;
            col_m   = '0;
         end
         if (bpf || hact) begin
            exp    = pattern_m ? lfsr_m : ramp_px(row_m, col_m);
            lfsr_m = lfsr_step(lfsr_m);
            col_m++;
         end else
            exp = '0;                             // blank outside bpf and hact
         check_pixel("pixel", exp, d);
         frame_sum += 32'(d);
         if (hact)
            hact_len++;
         if (bpf)
            bpf_len++;
         if (prev_vact && !vact) begin
            check_count("hact pulses", nrows_m, 16'(hact_cnt));
            last_sum = frame_sum;
            fall_cyc = cycle;
            frames_done++;
         end
         prev_vact = vact;
         prev_hact = hact;
         prev_bpf  = bpf;
      end
   end

   initial begin
      int unsigned seed_val;
      int          nvec, target, trig_cyc, idle;
      logic [31:0] ll, nc, nr, nb, ng, dly, pat, cnt, sum;
      seed_val = $urandom(40207);
      MCLK    = 0;
      c       = 1;
      trig    = 0;
      paddr   = '0;
      psel    = 0;
      penable = 0;
      pwrite  = 0;
      pwdata  = '0;
      $readmemh("verif/sensor_vectors.txt", vmem);
      nvec = 0;
      while (nvec < 32 && vmem[nvec*9] != 0) begin
         limit += 2 * ((vmem[nvec*9+5] + vmem[nvec*9+2] + 3) * vmem[nvec*9] + 200);
         nvec++;
      end
      limit += 400;   // register access test
      repeat (4) @(posedge MCLK);
      c <= 1'b0;

      // register access
      read_reg("line_len reset", sensor_regs_pkg::REG_LINE_LEN, 32'd192, 1'b0);
      read_reg("status reset", sensor_regs_pkg::REG_STATUS, 32'd0, 1'b0);
      write_reg("ctrl", sensor_regs_pkg::REG_CTRL, 32'h3, 1'b0);
      read_reg("ctrl", sensor_regs_pkg::REG_CTRL, 32'h3, 1'b0);
      write_reg("ncols", sensor_regs_pkg::REG_NCOLS, 32'h5A5, 1'b0);
      read_reg("ncols", sensor_regs_pkg::REG_NCOLS, 32'h5A5, 1'b0);
      write_reg("nrows", sensor_regs_pkg::REG_NROWS, 32'hA5A, 1'b0);
      read_reg("nrows", sensor_regs_pkg::REG_NROWS, 32'hA5A, 1'b0);
      write_reg("nbpf", sensor_regs_pkg::REG_NBPF, 32'h1234, 1'b0);
      read_reg("nbpf", sensor_regs_pkg::REG_NBPF, 32'h1234, 1'b0);
      write_reg("ngap", sensor_regs_pkg::REG_NGAP, 32'hBEEF, 1'b0);
      read_reg("ngap", sensor_regs_pkg::REG_NGAP, 32'hBEEF, 1'b0);
      write_reg("trig_dly", sensor_regs_pkg::REG_TRIG_DLY, 32'h0077, 1'b0);
      read_reg("trig_dly", sensor_regs_pkg::REG_TRIG_DLY, 32'h0077, 1'b0);
      write_reg("line_len", sensor_regs_pkg::REG_LINE_LEN, 32'h4321, 1'b0);
      read_reg("line_len", sensor_regs_pkg::REG_LINE_LEN, 32'h4321, 1'b0);
      write_reg("status", sensor_regs_pkg::REG_STATUS, 32'hFFFF_FFFF, 1'b1);
      read_reg("status after write", sensor_regs_pkg::REG_STATUS, 32'd0, 1'b0);
      write_reg("unmapped", 8'h20, 32'h1, 1'b1);
      read_reg("unmapped", 8'h20, 32'd0, 1'b1);
      read_reg("ctrl after unmapped", sensor_regs_pkg::REG_CTRL, 32'h3, 1'b0);

      // frames from the vector file
      for (int v = 0; v < nvec; v++) begin
         ll  = vmem[v*9];
         nc  = vmem[v*9+1];
         nr  = vmem[v*9+2];
         nb  = vmem[v*9+3];
         ng  = vmem[v*9+4];
         dly = vmem[v*9+5];
         pat = vmem[v*9+6];
         cnt = vmem[v*9+7];
         sum = vmem[v*9+8];
         ll_m      = 16'(ll);
         ncols_m   = 16'(nc);
         nrows_m   = 16'(nr);
         nbpf_m    = 16'(nb);
         pattern_m = pat[0];
         write_reg("line_len", sensor_regs_pkg::REG_LINE_LEN, ll, 1'b0);
         write_reg("ncols", sensor_regs_pkg::REG_NCOLS, nc, 1'b0);
         write_reg("nrows", sensor_regs_pkg::REG_NROWS, nr, 1'b0);
         write_reg("nbpf", sensor_regs_pkg::REG_NBPF, nb, 1'b0);
         write_reg("ngap", sensor_regs_pkg::REG_NGAP, ng, 1'b0);
         write_reg("trig_dly", sensor_regs_pkg::REG_TRIG_DLY, dly, 1'b0);
         write_reg("ctrl", sensor_regs_pkg::REG_CTRL, {30'd0, cnt[0], pat[0]}, 1'b0);
         idle = int'($urandom % 16);
         repeat (idle) @(posedge MCLK);
         @(posedge MCLK);
         trig     <= 1'b1;
         trig_cyc = cycle + 1;   // counter updates after this edge
         @(posedge MCLK);
         trig <= 1'b0;
         target = frames_started + 1;
         while (frames_started != target) @(negedge MCLK);
         check_count("trigger delay", 16'(dly * ll + 2), 16'(start_cyc - trig_cyc));
         read_reg("status busy", sensor_regs_pkg::REG_STATUS,
                  {16'(frames_done), 15'd0, 1'b1}, 1'b0);   // mid frame
         target = frames_done + 1;
         while (frames_done != target) @(negedge MCLK);
         check_apb("frame sum", sum, last_sum);
         if (cnt[0]) begin
            // stop after the next frame
            write_reg("ctrl", sensor_regs_pkg::REG_CTRL, {31'd0, pat[0]}, 1'b0);
            target = frames_done + 1;
            while (frames_done != target) @(negedge MCLK);
            check_count("vact gap", 16'd1, 16'(last_gap));
            check_apb("second frame sum", sum, last_sum);
         end
         read_reg("status count", sensor_regs_pkg::REG_STATUS, {16'(frames_done), 16'd0}, 1'b0);
         target = frames_started;
         repeat (2 * ll) @(posedge MCLK);   // still mode, nothing may start
         check_count("frames without trigger", 16'(target), 16'(frames_started));
      end

      $display("all tests passed");
      $finish;
   end

endmodule

//--- verif/sensor_vectors.txt
// columns, hex: line_len ncols nrows nbpf ngap trig_dly pattern cont frame_sum
// frame_sum is the sum of all pixel words of one frame
// ramp, bpf and gap, one delay line
14 08 03 02 03 01 0 0 00000057
// ramp, no bpf
10 0A 02 00 02 00 0 0 0000005A
// ramp, line fully used, two delay lines
0C 06 02 03 03 02 0 0 00000024
// lfsr, four hact pixels
0A 02 02 00 01 00 1 0 00002215
// lfsr, pixels split over bpf and hact
0E 01 02 01 02 01 1 0 00002215
// ramp, continuous
12 05 02 02 01 00 0 1 00000016
// lfsr, continuous, one row
0A 04 01 00 02 01 1 1 00002215
// ramp, longer line
28 1E 04 04 02 00 0 0 000006E4

//--- all.f
verilog/sensor_video_pkg.sv
verilog/sensor_regs_pkg.sv
verilog/sensor_apb_regs.sv
verilog/sensor_frame_fsm.sv
verilog/sensor_pixel_out.sv
verilog/sensor_top.sv
verif/sensor_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f all.f --top-module sensor_tb -o sensor_sim &&
./obj_dir/sensor_sim || exit 1
